/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert --top-module dlx_core_tb -Mdir obj_dir -f filelist.f
	./obj_dir/Vdlx_core_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
	  echo "test failed"; exit 1; \
	else \
	  echo "test passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* design/dlx_core_pkg.sv */
`default_nettype none

package dlx_core_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [2:0] {
    FLOW_NEXT,
    FLOW_BEQZ,
    FLOW_BNEZ,
    FLOW_JUMP_REL,
    FLOW_JUMP_REG
  } flow_t;

  typedef struct packed {
    dlx_isa_pkg::word_t     pc;
    dlx_isa_pkg::word_t     pc_plus_four;
    alu_op_t                alu_op;
    flow_t                  flow;
    dlx_isa_pkg::word_t     operand_a;
    dlx_isa_pkg::word_t     operand_b;   // rs2 value or extended immediate
    dlx_isa_pkg::word_t     offset;      // sign extended displacement
    dlx_isa_pkg::reg_addr_t dest;
    logic                   write;
    logic                   link;
  } decoded_t;

  typedef struct packed {
    logic               taken;
    dlx_isa_pkg::word_t target;
  } redirect_t;

  typedef struct packed {
    dlx_isa_pkg::word_t     pc;
    logic                   write;
    dlx_isa_pkg::reg_addr_t dest;
    dlx_isa_pkg::word_t     data;
  } retire_t;

endpackage

`default_nettype wire

/* design/dlx_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dlx_core_top #(
  parameter dlx_isa_pkg::word_t reset_address = '0
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  stall,
  input  wire dlx_isa_pkg::word_t    instr_data,
  output      dlx_isa_pkg::word_t    instr_addr,
  output      dlx_core_pkg::retire_t retire,
  output      logic                  retire_valid
);

  import dlx_isa_pkg::*;
  import dlx_core_pkg::*;

  word_t     pc_plus_four;
  redirect_t redirect;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  decoded_t  decoded;
  retire_t   result;

  instr_fetch #(
    .reset_address(reset_address)
  ) fetch_i (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .instr_addr  (instr_addr),
    .pc_plus_four(pc_plus_four)
  );

  instr_decode decode_i (
    .instr_data  (instr_data),
    .pc          (instr_addr), // word on instr_data belongs to this address
    .pc_plus_four(pc_plus_four),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .decoded     (decoded)
  );

  execute_unit execute_i (
    .decoded (decoded),
    .redirect(redirect),
    .result  (result)
  );

  result_writeback writeback_i (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .result      (result),
    .retire      (retire),
    .retire_valid(retire_valid)
  );

endmodule

`default_nettype wire

/* design/dlx_isa_pkg.sv */
`default_nettype none

package dlx_isa_pkg;

  localparam int WORD_WIDTH   = 32;
  localparam int REG_COUNT    = 32;
  localparam int REG_BITS     = 5;
  localparam int OPCODE_WIDTH = 6;
  localparam int FUNCT_WIDTH  = 6;
  localparam int IMM_WIDTH    = 16;

  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [REG_BITS-1:0]     reg_addr_t;
  typedef logic [OPCODE_WIDTH-1:0] opcode_t;
  typedef logic [FUNCT_WIDTH-1:0]  funct_t;
  typedef logic [IMM_WIDTH-1:0]    imm16_t;

  // primary opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQZ  = 6'h04;
  localparam opcode_t OP_BNEZ  = 6'h05;
  localparam opcode_t OP_ADDI  = 6'h08;
  localparam opcode_t OP_ANDI  = 6'h0c;
  localparam opcode_t OP_ORI   = 6'h0d;
  localparam opcode_t OP_XORI  = 6'h0e;
  localparam opcode_t OP_JR    = 6'h12;
  localparam opcode_t OP_JALR  = 6'h13;

  // R-type function field
  localparam funct_t FN_ADD = 6'h20;
  localparam funct_t FN_SUB = 6'h22;
  localparam funct_t FN_AND = 6'h24;
  localparam funct_t FN_OR  = 6'h25;
  localparam funct_t FN_XOR = 6'h26;
  localparam funct_t FN_SLT = 6'h2a;

  localparam reg_addr_t LINK_REG = 5'd31; // jal and jalr target

endpackage

`default_nettype wire

/* design/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  wire dlx_core_pkg::decoded_t  decoded,
  output      dlx_core_pkg::redirect_t redirect,
  output      dlx_core_pkg::retire_t   result
);

  import dlx_isa_pkg::*;
  import dlx_core_pkg::*;

  word_t a;
  word_t b;
  word_t alu_out;
  word_t rel_target;
  logic  a_is_zero;

  assign a = decoded.operand_a;
  assign b = decoded.operand_b;

  always_comb begin
    case (decoded.alu_op)
      ALU_ADD:    alu_out = a + b;
      ALU_SUB:    alu_out = a - b;
      ALU_AND:    alu_out = a & b;
      ALU_OR:     alu_out = a | b;
      ALU_XOR:    alu_out = a ^ b;
      ALU_SLT:    alu_out = {31'd0, $signed(a) < $signed(b)}; // signed compare
      ALU_PASS_B: alu_out = b;
      default:    alu_out = b;
    endcase
  end

  // branches and j/jal are relative to the next instruction
  assign rel_target = decoded.pc_plus_four + decoded.offset;
  assign a_is_zero  = (a == '0);

  always_comb begin
    redirect.taken  = 1'b0;
    redirect.target = rel_target;
    case (decoded.flow)
      FLOW_BEQZ:     redirect.taken = a_is_zero;
      FLOW_BNEZ:     redirect.taken = !a_is_zero;
      FLOW_JUMP_REL: redirect.taken = 1'b1;
      FLOW_JUMP_REG: begin
        redirect.taken  = 1'b1;
        redirect.target = a; // low bits cleared in decode
      end
      default:       redirect.taken = 1'b0;
    endcase
  end

  assign result.pc    = decoded.pc;
  assign result.write = decoded.write;
  assign result.dest  = decoded.dest;
  assign result.data  = decoded.link ? decoded.pc_plus_four : alu_out; // no delay slot

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  wire dlx_isa_pkg::word_t     instr_data,
  input  wire dlx_isa_pkg::word_t     pc,
  input  wire dlx_isa_pkg::word_t     pc_plus_four,
  output      dlx_isa_pkg::reg_addr_t rs1_addr,
  output      dlx_isa_pkg::reg_addr_t rs2_addr,
  input  wire dlx_isa_pkg::word_t     rs1_data,
  input  wire dlx_isa_pkg::word_t     rs2_data,
  output      dlx_core_pkg::decoded_t decoded
);

  import dlx_isa_pkg::*;
  import dlx_core_pkg::*;

  opcode_t   opcode;
  funct_t    funct;
  reg_addr_t rd;
  imm16_t    imm;
  word_t     imm_sext;
  word_t     imm_zext;
  word_t     disp_sext;
  logic      writes_reg;

  assign opcode   = instr_data[31:26];
  assign rs1_addr = instr_data[25:21];
  assign rs2_addr = instr_data[20:16]; // also rt for I-type
  assign rd       = instr_data[15:11];
  assign funct    = instr_data[5:0];
  assign imm      = instr_data[15:0];

  assign imm_sext  = {{16{imm[15]}}, imm};
  assign imm_zext  = {16'h0000, imm};
  assign disp_sext = {{6{instr_data[25]}}, instr_data[25:0]};

  always_comb begin
    decoded              = '0;
    decoded.pc           = pc;
    decoded.pc_plus_four = pc_plus_four;
    decoded.alu_op       = ALU_PASS_B;
    decoded.flow         = FLOW_NEXT;
    decoded.operand_a    = rs1_data;
    decoded.operand_b    = imm_sext;
    decoded.offset       = imm_sext;
    decoded.dest         = rs2_addr;
    decoded.link         = 1'b0;
    writes_reg           = 1'b0;

    case (opcode)
      OP_RTYPE: begin
        decoded.operand_b = rs2_data;
        decoded.dest      = rd;
        writes_reg        = 1'b1;
        case (funct)
          FN_ADD:  decoded.alu_op = ALU_ADD;
          FN_SUB:  decoded.alu_op = ALU_SUB;
          FN_AND:  decoded.alu_op = ALU_AND;
          FN_OR:   decoded.alu_op = ALU_OR;
          FN_XOR:  decoded.alu_op = ALU_XOR;
          FN_SLT:  decoded.alu_op = ALU_SLT;
          default: writes_reg     = 1'b0; // unknown function is a no-op
        endcase
      end
      OP_ADDI: begin
        decoded.alu_op = ALU_ADD;
        writes_reg     = 1'b1;
      end
      OP_ANDI, OP_ORI, OP_XORI: begin
        decoded.operand_b = imm_zext; // logical ops zero extend
        decoded.alu_op    = (opcode == OP_ANDI) ? ALU_AND :
                            (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
        writes_reg        = 1'b1;
      end
      OP_BEQZ: decoded.flow = FLOW_BEQZ;
      OP_BNEZ: decoded.flow = FLOW_BNEZ;
      OP_J, OP_JAL: begin
        decoded.flow   = FLOW_JUMP_REL;
        decoded.offset = disp_sext;
        decoded.link   = (opcode == OP_JAL);
        decoded.dest   = LINK_REG;
        writes_reg     = (opcode == OP_JAL);
      end
      OP_JR, OP_JALR: begin
        decoded.flow      = FLOW_JUMP_REG;
        decoded.operand_a = {rs1_data[31:2], 2'b00}; // word aligned target
        decoded.link      = (opcode == OP_JALR);
        decoded.dest      = LINK_REG;
        writes_reg        = (opcode == OP_JALR);
      end
      default: ; // unknown opcode retires as a no-op
    endcase

    decoded.write = writes_reg && (decoded.dest != '0); // r0 stays zero
  end

endmodule

`default_nettype wire

/* design/instr_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
  parameter dlx_isa_pkg::word_t reset_address = '0
) (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    stall,
  input  wire dlx_core_pkg::redirect_t redirect,
  output      dlx_isa_pkg::word_t      instr_addr,
  output      dlx_isa_pkg::word_t      pc_plus_four
);

  import dlx_isa_pkg::*;

  word_t pc;
  word_t next_pc;

  assign pc_plus_four = pc + 32'd4;

  // execute has already resolved the condition
  assign next_pc = redirect.taken ? redirect.target : pc_plus_four;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= reset_address;
    end else if (!stall) begin
      pc <= next_pc;
    end // hold while stalled
  end

  assign instr_addr = pc;

endmodule

`default_nettype wire

/* design/result_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   stall,
  input  wire dlx_isa_pkg::reg_addr_t rs1_addr,
  input  wire dlx_isa_pkg::reg_addr_t rs2_addr,
  output      dlx_isa_pkg::word_t     rs1_data,
  output      dlx_isa_pkg::word_t     rs2_data,
  input  wire dlx_core_pkg::retire_t  result,
  output      dlx_core_pkg::retire_t  retire,
  output      logic                   retire_valid
);

  import dlx_isa_pkg::*;
  import dlx_core_pkg::*;

  word_t regs [REG_COUNT];

  // r0 is hardwired to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (!stall && result.write) begin
      regs[result.dest] <= result.data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      retire       <= '0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= !stall;
      if (!stall) begin
        retire <= result;
      end else begin
        retire.write <= 1'b0; // nothing retires in a stalled cycle
      end
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
design/dlx_isa_pkg.sv
design/dlx_core_pkg.sv
design/instr_fetch.sv
design/instr_decode.sv
design/execute_unit.sv
design/result_writeback.sv
design/dlx_core_top.sv
testbench/clock_gen.sv
testbench/dlx_core_assertions.sv
testbench/dlx_core_tb.sv

/* testbench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int half_period = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #half_period clk = ~clk; // 8 ns period with the default

endmodule

`default_nettype wire

/* testbench/dlx_core_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module dlx_core_assertions (
  input wire logic                  clk,
  input wire logic                  reset,
  input wire logic                  stall,
  input wire dlx_isa_pkg::word_t    instr_addr,
  input wire dlx_core_pkg::retire_t retire
);

  write_dest_nonzero: assert property (@(posedge clk) disable iff (reset)
    retire.write |-> (retire.dest != 5'd0))
    else $error("retired write targets r0");

  addr_word_aligned: assert property (@(posedge clk) disable iff (reset)
    instr_addr[1:0] == 2'b00)
    else $error("instruction address is not word aligned");

  // pc must not move across a stalled edge
  addr_held_on_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(instr_addr))
    else $error("instruction address changed during a stall");

endmodule

`default_nettype wire

/* testbench/dlx_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dlx_core_tb;

  import dlx_isa_pkg::*;
  import dlx_core_pkg::*;

  typedef struct packed {
    word_t     instr;
    logic      stall;
    word_t     addr;
    logic      write;
    reg_addr_t dest;
    word_t     data;
  } table_row_t;

  localparam word_t UNKNOWN_OP = 32'hfc000000; // opcode 0x3f

  logic    clk;
  logic    reset;
  logic    stall;
  word_t   instr_data;
  word_t   instr_addr;
  retire_t retire;
  logic    retire_valid;

  table_row_t rows[$];
  int         errors = 0;
  int         checks = 0;
  logic       released;

  clock_gen #(.half_period(4)) clock_i (.clk(clk));

  dlx_core_top #(
    .reset_address(32'h100)
  ) dut_i (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .instr_data  (instr_data),
    .instr_addr  (instr_addr),
    .retire      (retire),
    .retire_valid(retire_valid)
  );

  bind dlx_core_top dlx_core_assertions assertions_i (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .instr_addr(instr_addr),
    .retire    (retire)
  );

  function automatic word_t rtype_word(funct_t fn, reg_addr_t rd, reg_addr_t rs1,
                                       reg_addr_t rs2);
    return {OP_RTYPE, rs1, rs2, rd, 5'd0, fn};
  endfunction

  function automatic word_t itype_word(opcode_t op, reg_addr_t rt, reg_addr_t rs1,
                                       imm16_t imm);
    return {op, rs1, rt, imm};
  endfunction

  function automatic word_t jtype_word(opcode_t op, logic [25:0] disp);
    return {op, disp};
  endfunction

  task automatic add_row(word_t instr, logic stall_bit, word_t addr, logic write,
                         reg_addr_t dest, word_t data);
    rows.push_back('{instr, stall_bit, addr, write, dest, data});
  endtask

  task automatic compare_word(string what, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic load_table();
    add_row(itype_word(OP_ADDI, 5'd1, 5'd0, 16'h0005), 1'b0, 32'h100, 1'b1, 5'd1, 32'h5);
    add_row(itype_word(OP_ADDI, 5'd2, 5'd0, 16'hfffd), 1'b0, 32'h104, 1'b1, 5'd2, 32'hfffffffd);
    add_row(itype_word(OP_ORI, 5'd3, 5'd0, 16'h8000), 1'b0, 32'h108, 1'b1, 5'd3, 32'h8000);
    add_row(rtype_word(FN_ADD, 5'd4, 5'd1, 5'd2), 1'b0, 32'h10c, 1'b1, 5'd4, 32'h2);
    add_row(rtype_word(FN_SUB, 5'd5, 5'd4, 5'd1), 1'b0, 32'h110, 1'b1, 5'd5, 32'hfffffffd);
    add_row(rtype_word(FN_AND, 5'd6, 5'd5, 5'd3), 1'b0, 32'h114, 1'b1, 5'd6, 32'h8000);
    add_row(rtype_word(FN_OR, 5'd7, 5'd6, 5'd1), 1'b0, 32'h118, 1'b1, 5'd7, 32'h8005);
    add_row(rtype_word(FN_XOR, 5'd8, 5'd7, 5'd5), 1'b0, 32'h11c, 1'b1, 5'd8, 32'hffff7ff8);
    add_row(rtype_word(FN_SLT, 5'd9, 5'd2, 5'd1), 1'b0, 32'h120, 1'b1, 5'd9, 32'h1);
    add_row(rtype_word(FN_SLT, 5'd10, 5'd1, 5'd2), 1'b0, 32'h124, 1'b1, 5'd10, 32'h0);
    add_row(rtype_word(FN_ADD, 5'd0, 5'd1, 5'd1), 1'b0, 32'h128, 1'b0, 5'd0, 32'h0);
    add_row(rtype_word(FN_ADD, 5'd11, 5'd0, 5'd1), 1'b0, 32'h12c, 1'b1, 5'd11, 32'h5);
    // branches: taken, not taken, not taken, taken backward
    add_row(itype_word(OP_BEQZ, 5'd0, 5'd10, 16'h0008), 1'b0, 32'h130, 1'b0, 5'd0, 32'h0);
    add_row(itype_word(OP_BNEZ, 5'd0, 5'd10, 16'h0010), 1'b0, 32'h13c, 1'b0, 5'd0, 32'h0);
    add_row(itype_word(OP_BEQZ, 5'd0, 5'd1, 16'h0010), 1'b0, 32'h140, 1'b0, 5'd0, 32'h0);
    add_row(itype_word(OP_BNEZ, 5'd0, 5'd1, 16'hfff0), 1'b0, 32'h144, 1'b0, 5'd0, 32'h0);
    add_row(jtype_word(OP_J, 26'h20), 1'b0, 32'h138, 1'b0, 5'd0, 32'h0);
    add_row(jtype_word(OP_JAL, 26'h40), 1'b0, 32'h15c, 1'b1, 5'd31, 32'h160);
    add_row(itype_word(OP_ADDI, 5'd12, 5'd0, 16'h0203), 1'b0, 32'h1a0, 1'b1, 5'd12, 32'h203);
    add_row(itype_word(OP_JR, 5'd0, 5'd12, 16'h0000), 1'b0, 32'h1a4, 1'b0, 5'd0, 32'h0);
    // two stalled cycles, then the same word retires
    add_row(itype_word(OP_ADDI, 5'd13, 5'd31, 16'h0004), 1'b1, 32'h200, 1'b0, 5'd0, 32'h0);
    add_row(itype_word(OP_ADDI, 5'd13, 5'd31, 16'h0004), 1'b1, 32'h200, 1'b0, 5'd0, 32'h0);
    add_row(itype_word(OP_ADDI, 5'd13, 5'd31, 16'h0004), 1'b0, 32'h200, 1'b1, 5'd13, 32'h164);
    add_row(itype_word(OP_JALR, 5'd0, 5'd13, 16'h0000), 1'b0, 32'h204, 1'b1, 5'd31, 32'h208);
    add_row(rtype_word(FN_ADD, 5'd14, 5'd31, 5'd0), 1'b0, 32'h164, 1'b1, 5'd14, 32'h208);
    add_row(UNKNOWN_OP, 1'b0, 32'h168, 1'b0, 5'd0, 32'h0);
    add_row(itype_word(OP_ADDI, 5'd15, 5'd14, 16'h0008), 1'b0, 32'h16c, 1'b1, 5'd15, 32'h210);
    // logical immediates zero extend
    add_row(itype_word(OP_ANDI, 5'd16, 5'd8, 16'hff0f), 1'b0, 32'h170, 1'b1, 5'd16, 32'h7f08);
    add_row(itype_word(OP_XORI, 5'd17, 5'd5, 16'h8001), 1'b0, 32'h174, 1'b1, 5'd17, 32'hffff7ffc);
  endtask

  task automatic wait_for_release(output logic ok);
    int cycles;
    cycles = 0;
    while (reset !== 1'b0 && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    ok = (reset === 1'b0);
  endtask

  task automatic run_table();
    table_row_t row;
    foreach (rows[i]) begin
      row = rows[i];
      @(negedge clk);
      compare_word($sformatf("row %0d instr_addr", i), instr_addr, row.addr);
      instr_data = row.instr;
      stall      = row.stall;
      @(posedge clk);
      #1; // let the retire registers settle
      compare_bit($sformatf("row %0d retire_valid", i), retire_valid, !row.stall);
      if (row.stall) begin
        compare_bit($sformatf("row %0d retire.write", i), retire.write, 1'b0);
      end else begin
        compare_word($sformatf("row %0d retire.pc", i), retire.pc, row.addr);
        compare_bit($sformatf("row %0d retire.write", i), retire.write, row.write);
        if (row.write) begin
          compare_word($sformatf("row %0d retire.dest", i), {27'd0, retire.dest},
                       {27'd0, row.dest});
          compare_word($sformatf("row %0d retire.data", i), retire.data, row.data);
        end
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
  end

  initial begin
    #20000;
    $display("simulation did not finish within 20000 ns");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    stall      = 1'b1; // pc holds until the first row
    instr_data = '0;
    load_table();
    wait_for_release(released);
    if (!released) begin
      $display("reset was not released within 100 cycles");
      $display("TB FAILED");
      $finish;
    end else begin
      compare_word("instr_addr after reset", instr_addr, 32'h100);
      compare_bit("retire_valid after reset", retire_valid, 1'b0);
      compare_bit("retire.write after reset", retire.write, 1'b0);
      run_table();
      @(negedge clk);
      compare_word("final instr_addr", instr_addr, 32'h178);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
